/* Bender.yml */
package:
  name: iq_cluster

sources:
  - rtl/iq_isa_pkg.sv
  - rtl/iq_types_pkg.sv
  - rtl/iq_queue_ctrl.sv
  - rtl/iq_issue_queue.sv
  - rtl/iq_dispatch.sv
  - rtl/iq_issue_arbiter.sv
  - rtl/iq_cluster.sv
  - target: test
    files:
      - tb/iq_cluster_tb.sv

/* iq_cluster.f */
rtl/iq_isa_pkg.sv
rtl/iq_types_pkg.sv
rtl/iq_queue_ctrl.sv
rtl/iq_issue_queue.sv
rtl/iq_dispatch.sv
rtl/iq_issue_arbiter.sv
rtl/iq_cluster.sv
tb/iq_cluster_tb.sv

/* rtl/iq_cluster.sv */
module iq_cluster #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                     clk,
    input  logic                     i_rst_n,
    input  logic                     i_flush,
    input  iq_types_pkg::iq_wb_req_t i_wb,
    input  logic                     i_issue_ready,
    output iq_types_pkg::iq_wb_rsp_t o_wb,
    output logic                     o_issue_valid,
    output iq_types_pkg::iq_entry_t  o_issue
);

    import iq_types_pkg::*;

    logic [NUM_QUEUES-1:0] push;
    logic [NUM_QUEUES-1:0] pop;
    logic [NUM_QUEUES-1:0] full;
    logic [NUM_QUEUES-1:0] empty;
    iq_entry_t             entry;
    iq_entry_t             heads [NUM_QUEUES];

    iq_dispatch dispatch_i (
        .clk     (clk),
        .i_rst_n (i_rst_n),
        .i_wb    (i_wb),
        .i_full  (full),
        .i_empty (empty),
        .o_wb    (o_wb),
        .o_push  (push),
        .o_entry (entry)
    );

    // Each execution class has its own queue and all of them share the dispatch entry bus
    for (genvar q = 0; q < NUM_QUEUES; q++) begin : gen_queue
        iq_issue_queue #(
            .QUEUE_DEPTH (QUEUE_DEPTH)
        ) queue_i (
            .clk     (clk),
            .i_rst_n (i_rst_n),
            .i_flush (i_flush),
            .i_push  (push[q]),
            .i_entry (entry),
            .i_pop   (pop[q]),
            .o_head  (heads[q]),
            .o_full  (full[q]),
            .o_empty (empty[q])
        );
    end

    iq_issue_arbiter arbiter_i (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_empty       (empty),
        .i_heads       (heads),
        .i_issue_ready (i_issue_ready),
        .o_pop         (pop),
        .o_issue_valid (o_issue_valid),
        .o_issue       (o_issue)
    );

endmodule

/* rtl/iq_dispatch.sv */
module iq_dispatch (
    input  logic                                  clk,
    input  logic                                  i_rst_n,
    input  iq_types_pkg::iq_wb_req_t              i_wb,
    input  logic [iq_types_pkg::NUM_QUEUES-1:0]   i_full,
    input  logic [iq_types_pkg::NUM_QUEUES-1:0]   i_empty,
    output iq_types_pkg::iq_wb_rsp_t              o_wb,
    output logic [iq_types_pkg::NUM_QUEUES-1:0]   o_push,
    output iq_types_pkg::iq_entry_t               o_entry
);

    import iq_isa_pkg::*;
    import iq_types_pkg::*;

    iq_insn_u    insn;
    iq_class_e   target;
    logic        req;
    logic        is_push;
    logic        is_status;
    logic        stall;
    logic        ack_next;
    logic        ack_r;
    logic [31:0] rdat_r;

    // The master holds its data stable until ack, so decode straight off the bus
    assign insn = i_wb.dat;

    always_comb begin
        if (insn.r.fmt == FMT_REG) begin
            o_entry = '{cls: insn.r.cls, rd: insn.r.rd, rs1: insn.r.rs1, rs2: insn.r.rs2,
                        rs2_valid: 1'b1, operand: 32'(insn.r.funct)};
        end else begin
            o_entry = '{cls: insn.i.cls, rd: insn.i.rd, rs1: insn.i.rs1, rs2: 5'd0,
                        rs2_valid: 1'b0, operand: {{13{insn.i.imm[18]}}, insn.i.imm}};
        end
    end

    // A new request is one that has not been acknowledged yet
    assign req       = i_wb.cyc && i_wb.stb && !ack_r;
    assign is_push   = req && i_wb.we && (i_wb.adr == WB_ADDR_PUSH);
    assign is_status = !i_wb.we && (i_wb.adr == WB_ADDR_STATUS);
    assign target    = o_entry.cls;

    // Hold off ack while the target queue is full
    assign stall    = is_push && i_full[target];
    assign ack_next = req && !stall;
    assign o_push   = (is_push && !stall) ? (NUM_QUEUES'(1) << target) : '0;

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            ack_r <= 1'b0;
        end else begin
            ack_r <= ack_next;
        end
    end

    // Status word has full flags in the low nibble and empty flags above them
    always_ff @(posedge clk) begin
        if (ack_next) begin
            rdat_r <= is_status ? 32'({i_empty, i_full}) : '0;
        end
    end

    assign o_wb = '{ack: ack_r, dat: rdat_r};

    // A stalled push is decoded off the bus again next cycle, so the master must hold it
    a_stall_held: assert property (@(posedge clk) disable iff (!i_rst_n)
        stall |=> $stable(i_wb));

endmodule

/* rtl/iq_isa_pkg.sv */
package iq_isa_pkg;

    // Execution class, which doubles as the issue queue index
    typedef enum logic [1:0] {
        IQ_ALU    = 2'd0,
        IQ_MUL    = 2'd1,
        IQ_MEM    = 2'd2,
        IQ_BRANCH = 2'd3
    } iq_class_e;

    // Values of the format bit (bit 29)
    localparam logic FMT_REG = 1'b0;
    localparam logic FMT_IMM = 1'b1;

    // Register form carries two source registers and a function field
    typedef struct packed {
        iq_class_e   cls;
        logic        fmt;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [13:0] funct;
    } iq_reg_fmt_t;

    // Immediate form carries one source register and a signed immediate
    typedef struct packed {
        iq_class_e   cls;
        logic        fmt;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [18:0] imm;
    } iq_imm_fmt_t;

    // One instruction word, read through whichever view the format bit selects
    typedef union packed {
        iq_reg_fmt_t r;
        iq_imm_fmt_t i;
    } iq_insn_u;

endpackage

/* rtl/iq_issue_arbiter.sv */
module iq_issue_arbiter (
    input  logic                                clk,
    input  logic                                i_rst_n,
    input  logic [iq_types_pkg::NUM_QUEUES-1:0] i_empty,
    input  iq_types_pkg::iq_entry_t             i_heads [iq_types_pkg::NUM_QUEUES],
    input  logic                                i_issue_ready,
    output logic [iq_types_pkg::NUM_QUEUES-1:0] o_pop,
    output logic                                o_issue_valid,
    output iq_types_pkg::iq_entry_t             o_issue
);

    import iq_types_pkg::*;

    localparam int QIDX_W = $clog2(NUM_QUEUES);

    logic [QIDX_W-1:0] rr_ptr_r;
    logic [QIDX_W-1:0] grant_idx;
    logic              grant_valid;
    logic              transfer;

    // Walk the queues from the highest offset down so the nearest
    // non-empty queue after the pointer wins
    always_comb begin
        logic [QIDX_W-1:0] idx;
        grant_valid = 1'b0;
        grant_idx   = rr_ptr_r;
        for (int k = NUM_QUEUES - 1; k >= 0; k--) begin
            idx = rr_ptr_r + QIDX_W'(k);
            if (!i_empty[idx]) begin
                grant_valid = 1'b1;
                grant_idx   = idx;
            end
        end
    end

    assign o_issue_valid = grant_valid;
    assign o_issue       = i_heads[grant_idx];
    assign transfer      = grant_valid && i_issue_ready;
    assign o_pop         = transfer ? (NUM_QUEUES'(1) << grant_idx) : '0;

    // Next search starts just past the queue that was served
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            rr_ptr_r <= '0;
        end else if (transfer) begin
            rr_ptr_r <= grant_idx + 1'b1;
        end
    end

    // A queue is never served twice in a row while another queue is waiting
    a_rr_fair: assert property (@(posedge clk) disable iff (!i_rst_n)
        (transfer && (~i_empty != (NUM_QUEUES'(1) << grant_idx)))
            |=> !(transfer && (grant_idx == $past(grant_idx))));

endmodule

/* rtl/iq_issue_queue.sv */
module iq_issue_queue #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                    clk,
    input  logic                    i_rst_n,
    input  logic                    i_flush,
    input  logic                    i_push,
    input  iq_types_pkg::iq_entry_t i_entry,
    input  logic                    i_pop,
    output iq_types_pkg::iq_entry_t o_head,
    output logic                    o_full,
    output logic                    o_empty
);

    import iq_types_pkg::*;

    localparam int PTR_W = $clog2(QUEUE_DEPTH);

    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;

    // Entry storage, indexed by the head and tail pointers
    iq_entry_t entries [QUEUE_DEPTH];

    iq_queue_ctrl #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) ctrl_i (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_flush       (i_flush),
        .i_incr_head   (i_pop),
        .i_incr_tail   (i_push),
        .o_queue_head  (head),
        .o_queue_tail  (tail),
        .o_queue_full  (o_full),
        .o_queue_empty (o_empty)
    );

    // A push writes the tail slot; if a flush lands in the same cycle
    // the pointers reset and the written slot is simply never read
    always_ff @(posedge clk) begin
        if (i_push) begin
            entries[tail] <= i_entry;
        end
    end

    // Oldest entry is always on view for the arbiter
    assign o_head = entries[head];

endmodule

/* rtl/iq_queue_ctrl.sv */
module iq_queue_ctrl #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                           clk,
    input  logic                           i_rst_n,
    input  logic                           i_flush,
    input  logic                           i_incr_head,
    input  logic                           i_incr_tail,
    output logic [$clog2(QUEUE_DEPTH)-1:0] o_queue_head,
    output logic [$clog2(QUEUE_DEPTH)-1:0] o_queue_tail,
    output logic                           o_queue_full,
    output logic                           o_queue_empty
);

    localparam int PTR_W = $clog2(QUEUE_DEPTH);
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);
    localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(QUEUE_DEPTH - 1);
    localparam logic [CNT_W-1:0] CNT_DEPTH = CNT_W'(QUEUE_DEPTH);

    logic [PTR_W-1:0] head_r;
    logic [PTR_W-1:0] tail_r;
    logic [PTR_W-1:0] head_next;
    logic [PTR_W-1:0] tail_next;
    logic [CNT_W-1:0] free_r;
    logic [CNT_W-1:0] free_next;
    logic             full_r;
    logic             empty_r;

    // Step a pointer by one and wrap after the last slot
    function automatic logic [PTR_W-1:0] ptr_incr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_LAST) ? '0 : ptr + 1'b1;
    endfunction

    always_comb begin
        head_next = i_incr_head ? ptr_incr(head_r) : head_r;
        tail_next = i_incr_tail ? ptr_incr(tail_r) : tail_r;

        // Free slots drop on a lone push and come back on a lone pop
        case ({i_incr_head, i_incr_tail})
            2'b01:   free_next = free_r - 1'b1;
            2'b10:   free_next = free_r + 1'b1;
            default: free_next = free_r;
        endcase

        // Flush overrides whatever else happens this cycle
        if (i_flush) begin
            head_next = '0;
            tail_next = '0;
            free_next = CNT_DEPTH;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            head_r  <= '0;
            tail_r  <= '0;
            free_r  <= CNT_DEPTH;
            full_r  <= 1'b0;
            empty_r <= 1'b1;
        end else begin
            head_r  <= head_next;
            tail_r  <= tail_next;
            free_r  <= free_next;
            full_r  <= (free_next == '0);
            empty_r <= (free_next == CNT_DEPTH);
        end
    end

    assign o_queue_head  = head_r;
    assign o_queue_tail  = tail_r;
    assign o_queue_full  = full_r;
    assign o_queue_empty = empty_r;

    // The arbiter and the dispatch block must respect the flags this block hands out
    a_no_pop_empty: assert property (@(posedge clk) disable iff (!i_rst_n)
        !(i_incr_head && empty_r));
    a_no_push_full: assert property (@(posedge clk) disable iff (!i_rst_n)
        !(i_incr_tail && full_r));

endmodule

/* rtl/iq_types_pkg.sv */
package iq_types_pkg;

    // One queue per value of the class field
    localparam int NUM_QUEUES = 2 ** $bits(iq_isa_pkg::iq_class_e);

    // Wishbone word addresses
    localparam logic [1:0] WB_ADDR_PUSH   = 2'd0;
    localparam logic [1:0] WB_ADDR_STATUS = 2'd1;

    // Wishbone classic request from the host
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [1:0]  adr;
        logic [31:0] dat;
    } iq_wb_req_t;

    // Wishbone classic response to the host
    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } iq_wb_rsp_t;

    // Decoded entry as it sits in a queue and leaves on the issue port
    typedef struct packed {
        iq_isa_pkg::iq_class_e cls;
        logic [4:0]            rd;
        logic [4:0]            rs1;
        logic [4:0]            rs2;
        logic                  rs2_valid;
        logic [31:0]           operand;
    } iq_entry_t;

endpackage

/* tb/iq_cluster_tb.sv */
module iq_cluster_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import iq_isa_pkg::*;
    import iq_types_pkg::*;

    localparam int QUEUE_DEPTH = 4;
    localparam int WAIT_CYCLES = 20;

    // Each stimulus row holds the class, the format bit, the funct or immediate
    // and the operand it must decode to
    typedef struct packed {
        logic [1:0]  cls;
        logic        fmt;
        logic [18:0] field;
        logic [31:0] operand;
    } row_t;

    localparam row_t ROWS [8] = '{
        '{2'd0, 1'b0, 19'h00123, 32'h0000_0123},
        '{2'd2, 1'b1, 19'h7FFF8, 32'hFFFF_FFF8},
        '{2'd0, 1'b1, 19'h00064, 32'h0000_0064},
        '{2'd3, 1'b1, 19'h7FC00, 32'hFFFF_FC00},
        '{2'd1, 1'b0, 19'h03FFF, 32'h0000_3FFF},
        '{2'd2, 1'b0, 19'h02A5A, 32'h0000_2A5A},
        '{2'd0, 1'b1, 19'h3FFFF, 32'h0003_FFFF},
        '{2'd3, 1'b0, 19'h00001, 32'h0000_0001}
    };

    logic       clk;
    logic       rst_n;
    logic       flush;
    logic       issue_ready;
    logic       issue_valid;
    iq_wb_req_t wb_req;
    iq_wb_rsp_t wb_rsp;
    iq_entry_t  issue;

    // Reference model of the four queues and the round-robin pointer
    iq_entry_t   model_q [NUM_QUEUES][$];
    int          model_rr;
    int unsigned lcg_state = 9;
    int          test_errs;
    int          total_errs;
    int          tests_failed;

    iq_cluster #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) dut_i (
        .clk           (clk),
        .i_rst_n       (rst_n),
        .i_flush       (flush),
        .i_wb          (wb_req),
        .i_issue_ready (issue_ready),
        .o_wb          (wb_rsp),
        .o_issue_valid (issue_valid),
        .o_issue       (issue)
    );

    always #50 clk = ~clk;

    task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s = %h, expected %h", $time, name, got, exp);
            test_errs++;
        end
    endtask

    task automatic report_error(input string msg);
        $display("Error at %0t ns: %s", $time, msg);
        test_errs++;
    endtask

    function automatic logic [4:0] rand_reg();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[20:16];
    endfunction

    function automatic int model_size();
        int n;
        n = 0;
        for (int q = 0; q < NUM_QUEUES; q++) begin
            n += model_q[q].size();
        end
        return n;
    endfunction

    // Full flags sit in the low nibble and empty flags above them
    function automatic logic [31:0] model_status();
        logic [NUM_QUEUES-1:0] full;
        logic [NUM_QUEUES-1:0] empty;
        for (int q = 0; q < NUM_QUEUES; q++) begin
            full[q]  = (model_q[q].size() == QUEUE_DEPTH);
            empty[q] = (model_q[q].size() == 0);
        end
        return {24'd0, empty, full};
    endfunction

    // Pick the first non-empty queue at or after the pointer, then move past it
    task automatic model_pop(output iq_entry_t entry);
        int q;
        entry = '0;
        for (int k = 0; k < NUM_QUEUES; k++) begin
            q = (model_rr + k) % NUM_QUEUES;
            if (model_q[q].size() > 0) begin
                entry    = model_q[q].pop_front();
                model_rr = (q + 1) % NUM_QUEUES;
                break;
            end
        end
    endtask

    task automatic make_insn(input row_t row, output logic [31:0] word, output iq_entry_t exp);
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        rd  = rand_reg();
        rs1 = rand_reg();
        rs2 = rand_reg();
        if (row.fmt) begin
            word = {row.cls, 1'b1, rd, rs1, row.field};
        end else begin
            word = {row.cls, 1'b0, rd, rs1, rs2, row.field[13:0]};
        end
        exp.cls       = iq_class_e'(row.cls);
        exp.rd        = rd;
        exp.rs1       = rs1;
        exp.rs2       = row.fmt ? 5'd0 : rs2;
        exp.rs2_valid = !row.fmt;
        exp.operand   = row.operand;
    endtask

    task automatic wb_begin(input logic we, input logic [1:0] adr, input logic [31:0] dat);
        @(negedge clk);
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
    endtask

    // Drops the request once acked; otherwise leaves it held
    task automatic wb_wait(input int max_cycles, output bit acked, output logic [31:0] rdata);
        acked = 1'b0;
        rdata = '0;
        for (int n = 0; n < max_cycles && !acked; n++) begin
            @(negedge clk);
            if (wb_rsp.ack) begin
                acked      = 1'b1;
                rdata      = wb_rsp.dat;
                wb_req.cyc = 1'b0;
                wb_req.stb = 1'b0;
            end
        end
    endtask

    task automatic push_row(input row_t row);
        logic [31:0] word;
        logic [31:0] rdata;
        iq_entry_t   exp;
        bit          acked;
        make_insn(row, word, exp);
        wb_begin(1'b1, WB_ADDR_PUSH, word);
        wb_wait(WAIT_CYCLES, acked, rdata);
        if (acked) begin
            model_q[int'(exp.cls)].push_back(exp);
        end else begin
            report_error("push was not acknowledged");
        end
    endtask

    task automatic check_status();
        logic [31:0] rdata;
        bit          acked;
        wb_begin(1'b0, WB_ADDR_STATUS, '0);
        wb_wait(WAIT_CYCLES, acked, rdata);
        if (acked) begin
            compare("o_wb.dat", rdata, model_status());
        end else begin
            report_error("status read was not acknowledged");
        end
    endtask

    // Entries are sampled on the falling edge and transfer at the next rising edge
    task automatic issue_entries(input int n);
        iq_entry_t exp;
        int        got;
        int        idle;
        got         = 0;
        idle        = 0;
        issue_ready = 1'b1;
        while (got < n && idle < WAIT_CYCLES) begin
            if (issue_valid) begin
                model_pop(exp);
                compare("o_issue", issue, exp);
                got++;
                idle = 0;
            end else begin
                idle++;
            end
            @(negedge clk);
        end
        issue_ready = 1'b0;
        if (got < n) begin
            report_error("issue port went idle with entries still expected");
        end
        if (model_size() == 0) begin
            compare("o_issue_valid", issue_valid, 1'b0);
        end
    endtask

    task automatic end_test(input string name);
        if (test_errs == 0) begin
            $display("test %s: passed", name);
        end else begin
            $display("test %s: %0d errors", name, test_errs);
            tests_failed++;
        end
        total_errs += test_errs;
        test_errs = 0;
    endtask

    initial begin
        logic [31:0] rdata;
        bit          acked;
        clk          = 1'b0;
        rst_n        = 1'b0;
        flush        = 1'b0;
        issue_ready  = 1'b0;
        wb_req       = '0;
        model_rr     = 0;
        test_errs    = 0;
        total_errs   = 0;
        tests_failed = 0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;

        compare("o_issue_valid", issue_valid, 1'b0);
        check_status();
        end_test("reset_state");

        push_row(ROWS[0]);
        push_row(ROWS[1]);
        issue_entries(model_size());
        end_test("decode");

        foreach (ROWS[i]) begin
            push_row(ROWS[i]);
        end
        issue_entries(model_size());
        end_test("order");

        for (int i = 0; i < QUEUE_DEPTH; i++) begin
            push_row(ROWS[4]);
        end
        check_status();
        begin
            logic [31:0] word;
            iq_entry_t   exp;
            make_insn(ROWS[4], word, exp);
            wb_begin(1'b1, WB_ADDR_PUSH, word);
            wb_wait(WAIT_CYCLES, acked, rdata);
            if (acked) begin
                report_error("push to a full queue was acknowledged");
            end
            issue_entries(1);
            if (!acked) begin
                wb_wait(WAIT_CYCLES, acked, rdata);
            end
            if (acked) begin
                model_q[int'(exp.cls)].push_back(exp);
            end else begin
                report_error("stalled push was not acknowledged after a slot freed");
            end
        end
        issue_entries(model_size());
        end_test("full_stall");

        push_row(ROWS[2]);
        push_row(ROWS[3]);
        push_row(ROWS[5]);
        check_status();
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        for (int q = 0; q < NUM_QUEUES; q++) begin
            model_q[q].delete();
        end
        for (int n = 0; n < 4; n++) begin
            compare("o_issue_valid", issue_valid, 1'b0);
            @(negedge clk);
        end
        check_status();
        push_row(ROWS[6]);
        push_row(ROWS[7]);
        issue_entries(model_size());
        end_test("flush");

        $display("5 tests run, %0d failed, %0d check errors", tests_failed, total_errs);
        if (tests_failed == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule
